//--- bench/cpu16_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_tb;

	localparam int N_STORES = 10;
	localparam int TIMEOUT  = 400;  // ~40 instructions at worst latency plus margin

	logic        clk;
	logic        rst_n;
	logic [15:0] pc_out, instr, dmem_addr, dmem_wdata, dmem_rdata;
	logic        dmem_req, dmem_we, dmem_valid, hlt;
	logic [15:0] rom [64];
	logic [15:0] exp_addr [N_STORES];
	logic [15:0] exp_data [N_STORES];
	string       exp_name [N_STORES];
	int          store_idx;
	int          errors;
	int          bus_errors;
	int          cycles;

	always #50 clk = ~clk;

	cpu16_top i_dut (.*);

	data_mem_model #(.SEED(58952)) i_mem (.*);

	assign instr = (pc_out < 16'd128) ? rom[pc_out[6:1]] : 16'he000;  // NOP past the image

	task automatic expect_store(input int idx, input string name,
		input logic [15:0] addr, input logic [15:0] data);
		exp_name[idx] = name;
		exp_addr[idx] = addr;
		exp_data[idx] = data;
	endtask

	// ------------------------------
	// Program and expected stores
	// ------------------------------
	initial begin
		for (int i = 0; i < 64; i++) begin
			rom[i] = 16'he000;
		end
		rom[0]  = 16'hb134;  // r1 = 1234
		rom[1]  = 16'ha112;
		rom[2]  = 16'hbf00;  // r15 = 0100 base
		rom[3]  = 16'haf01;
		rom[4]  = 16'h91f0;
		rom[5]  = 16'hb2f0;  // r2 = 00f0
		rom[6]  = 16'ha200;
		rom[7]  = 16'h0312;  // ADD
		rom[8]  = 16'h93f1;
		rom[9]  = 16'h1431;  // SUB
		rom[10] = 16'h94f2;
		rom[11] = 16'h2542;  // XOR gives zero
		rom[12] = 16'h95f3;
		rom[13] = 16'h4614;  // SLL by 4
		rom[14] = 16'h96f4;
		rom[15] = 16'h0766;  // Distance two
		rom[16] = 16'h0877;  // Distance one
		rom[17] = 16'h1987;
		rom[18] = 16'h97f5;
		rom[19] = 16'h98f6;
		rom[20] = 16'h99f7;
		rom[21] = 16'h8a04;  // LW r10 from 0008
		rom[22] = 16'h0ba1;  // Uses r10 at once
		rom[23] = 16'h9bff;
		rom[24] = 16'h1cbb;  // Z set
		rom[25] = 16'hc202;  // EQ taken to 28
		rom[26] = 16'h9bfe;  // Shadowed stores
		rom[27] = 16'h9bfd;
		rom[28] = 16'h0d11;
		rom[29] = 16'hc402;  // LT not taken
		rom[30] = 16'h9dfe;
		rom[31] = 16'hf000;  // HLT
		rom[32] = 16'h9dfd;  // Must never store

		expect_store(0, "llb_lhb", 16'h0100, 16'h1234);
		expect_store(1, "add", 16'h0102, 16'h1324);
		expect_store(2, "sub", 16'h0104, 16'h00f0);
		expect_store(3, "xor", 16'h0106, 16'h0000);
		expect_store(4, "sll", 16'h0108, 16'h2340);
		expect_store(5, "fwd_dist2", 16'h010a, 16'h4680);
		expect_store(6, "fwd_dist1", 16'h010c, 16'h8d00);
		expect_store(7, "fwd_both", 16'h010e, 16'h4680);
		expect_store(8, "load_use", 16'h00fe, 16'h6c86);
		expect_store(9, "branch", 16'h00fc, 16'h2468);
	end

	// ------------------------------
	// Checks
	// ------------------------------
	always @(posedge clk) begin
		if (rst_n && dmem_req && dmem_valid && dmem_we) begin
			if (store_idx >= N_STORES) begin
				errors = errors + 1;
				$display("Unexpected store to %h with data %h", dmem_addr, dmem_wdata);
			end else begin
				assert (dmem_addr == exp_addr[store_idx]) else begin
					errors = errors + 1;
					$display("[FAIL] %s addr: expected %h, actual %h",
						exp_name[store_idx], exp_addr[store_idx], dmem_addr);
				end
				assert (dmem_wdata == exp_data[store_idx]) else begin
					errors = errors + 1;
					$display("[FAIL] %s data: expected %h, actual %h",
						exp_name[store_idx], exp_data[store_idx], dmem_wdata);
				end
			end
			store_idx = store_idx + 1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !hlt && !dmem_req)
		else begin
			errors = errors + 1;
			$display("hlt or dmem_req high during reset");
		end

	a_halt_after_stores: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(hlt) |-> store_idx == N_STORES)
		else begin
			errors = errors + 1;
			$display("[FAIL] halt stores: expected %0d, actual %0d", N_STORES, store_idx);
		end

	a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> $stable(pc_out))
		else begin
			errors = errors + 1;
			$display("pc_out moved after halt");
		end

	// Timeout guard
	always @(posedge clk) begin
		if (rst_n) begin
			cycles = cycles + 1;
			if (cycles >= TIMEOUT && !hlt) begin
				$display("Timeout: hlt did not rise within %0d cycles", TIMEOUT);
				$display("stores %0d of %0d, errors %0d, bus errors %0d",
					store_idx, N_STORES, errors, bus_errors);
				$display("Test FAILED");
				$finish;
			end
		end
	end

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		store_idx = 0;
		errors = 0;
		cycles = 0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;  // Released on a falling edge
		wait (hlt);
		repeat (10) @(negedge clk);  // Stray stores and PC movement show here
		$display("stores %0d of %0d, errors %0d, bus errors %0d",
			store_idx, N_STORES, errors, bus_errors);
		if (errors == 0 && bus_errors == 0 && store_idx == N_STORES) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/data_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_model #(
	parameter int SEED = 58952
) (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        dmem_req,
	input  wire        dmem_we,
	input  wire [15:0] dmem_addr,
	input  wire [15:0] dmem_wdata,
	output logic [15:0] dmem_rdata,
	output logic       dmem_valid,
	output int         bus_errors
);

	logic [15:0] mem [32768];  // Word addressed by addr[15:1]
	logic        active;
	logic        seeded;
	int          wait_cnt;

	// Fill depends on every address bit
	initial begin
		bus_errors = 0;
		seeded = 1'b0;
		for (int i = 0; i < 32768; i++) begin
			mem[i] = 16'(i * 2) ^ 16'h5a5a;
		end
	end

	// Answers on the falling edge so the DUT samples stable values
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dmem_valid <= 1'b0;
			dmem_rdata <= '0;
			active     <= 1'b0;
		end else if (dmem_valid) begin
			dmem_valid <= 1'b0;  // One-cycle valid
			active     <= 1'b0;
		end else if (dmem_req && !active) begin
			if (!seeded) begin
				void'($urandom(SEED));
				seeded = 1'b1;
			end
			active   <= 1'b1;
			wait_cnt <= int'($urandom % 6);  // Extra latency 0 to 5
		end else if (active) begin
			if (wait_cnt == 0) begin
				dmem_valid <= 1'b1;
				dmem_rdata <= mem[dmem_addr[15:1]];
				if (dmem_we) begin
					mem[dmem_addr[15:1]] <= dmem_wdata;
				end
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

	// ------------------------------
	// Bus rules
	// ------------------------------
	a_hold_fields: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req && !dmem_valid |=> $stable(dmem_addr) && $stable(dmem_we) && $stable(dmem_wdata))
		else begin
			bus_errors = bus_errors + 1;
			$display("Bus fields changed while a request was waiting");
		end

	a_gap_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_valid |=> !dmem_req)
		else begin
			bus_errors = bus_errors + 1;
			$display("New request started right after valid");
		end

endmodule

`default_nettype wire

//--- cpu16.f
design/cpu16_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu16_top.sv
bench/data_mem_model.sv
bench/cpu16_tb.sv

//--- design/cpu16_pkg.sv
`default_nettype none

package cpu16_pkg;

	// ------------------------------
	// Word and field types
	// ------------------------------
	typedef logic [15:0] word_t;     // Data, address or instruction
	typedef logic [3:0]  reg_sel_t;  // One of sixteen registers
	typedef logic [3:0]  opcode_t;   // instr[15:12]
	typedef logic [1:0]  flags_t;    // {Z, N}

	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 0;

	// ------------------------------
	// Opcodes
	// ------------------------------
	localparam opcode_t OP_ADD = 4'b0000;
	localparam opcode_t OP_SUB = 4'b0001;
	localparam opcode_t OP_XOR = 4'b0010;
	localparam opcode_t OP_SLL = 4'b0100;  // Shift by instr[3:0]
	localparam opcode_t OP_LW  = 4'b1000;
	localparam opcode_t OP_SW  = 4'b1001;
	localparam opcode_t OP_LHB = 4'b1010;
	localparam opcode_t OP_LLB = 4'b1011;
	localparam opcode_t OP_B   = 4'b1100;
	localparam opcode_t OP_HLT = 4'b1111;

	// Unassigned opcode 1110, no side effects anywhere
	// Fills flushed or stalled slots
	localparam word_t INSTR_NOP = 16'he000;

	// Branch conditions in instr[11:9]
	localparam logic [2:0] CC_NE = 3'b000;  // Z clear
	localparam logic [2:0] CC_EQ = 3'b001;  // Z set
	localparam logic [2:0] CC_LT = 3'b010;  // N set
	localparam logic [2:0] CC_AL = 3'b111;

	localparam word_t PC_STEP = 16'd2;  // Bytes per instruction

	// Data bus handshake
	typedef enum logic {MEM_IDLE, MEM_WAIT} mem_state_t;

endpackage

`default_nettype wire

//--- design/cpu16_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_top import cpu16_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	output word_t      pc_out,
	input  wire word_t instr,       // Combinational from pc_out
	output logic       dmem_req,
	output logic       dmem_we,
	output word_t      dmem_addr,
	output word_t      dmem_wdata,
	input  wire word_t dmem_rdata,
	input  wire        dmem_valid,
	output logic       hlt
);

	// ------------------------------
	// Stage to stage
	// ------------------------------
	word_t    if_pc, if_instr;
	logic     load_use_stall, halt_seen, branch_taken;
	word_t    branch_target;
	word_t    ex_pc, ex_instr, ex_a, ex_b;
	reg_sel_t ex_rs1, ex_rs2, ex_rd;
	logic     ex_regwrite, ex_load, ex_store, ex_halt;
	word_t    mem_result, mem_addr, mem_wdata, mem_fwd_data;
	reg_sel_t mem_rd;
	logic     mem_regwrite, mem_load, mem_store, mem_halt;
	logic     mem_busy;  // Global freeze
	word_t    wb_data;
	reg_sel_t wb_rd;
	logic     wb_regwrite;

	// Port names match the nets above
	fetch_stage i_fetch (
		.stall(mem_busy),
		.*
	);

	decode_stage i_decode (
		.stall(mem_busy),
		.*
	);

	execute_stage i_execute (
		.stall(mem_busy),
		.*
	);

	memory_stage i_memory (.*);

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu16_pkg::*; (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           stall,
	input  wire           branch_taken,
	input  wire word_t    if_pc,
	input  wire word_t    if_instr,
	input  wire           wb_regwrite,
	input  wire reg_sel_t wb_rd,
	input  wire word_t    wb_data,
	output logic          load_use_stall,
	output logic          halt_seen,
	output word_t         ex_pc,
	output word_t         ex_instr,
	output word_t         ex_a,
	output word_t         ex_b,
	output reg_sel_t      ex_rs1,
	output reg_sel_t      ex_rs2,
	output reg_sel_t      ex_rd,
	output logic          ex_regwrite,
	output logic          ex_load,
	output logic          ex_store,
	output logic          ex_halt
);

	word_t    regs [16];
	opcode_t  op;
	reg_sel_t rs1, rs2, rd;
	word_t    rd1, rd2;
	logic     is_rr, is_sll, is_lw, is_sw, is_imm8, is_hlt;
	logic     regwrite, use1, use2, halt_q;

	// Read port; r0 is always zero, a same-cycle writeback is bypassed
	function automatic word_t read_reg(input reg_sel_t sel);
		if (sel == '0) begin
			return '0;
		end else if (wb_regwrite && wb_rd == sel) begin
			return wb_data;
		end
		return regs[sel];
	endfunction

	// ------------------------------
	// Control decode
	// ------------------------------
	assign op      = if_instr[15:12];
	assign is_rr   = op inside {OP_ADD, OP_SUB, OP_XOR};
	assign is_sll  = (op == OP_SLL);
	assign is_lw   = (op == OP_LW);
	assign is_sw   = (op == OP_SW);
	assign is_imm8 = op inside {OP_LHB, OP_LLB};
	assign is_hlt  = (op == OP_HLT);

	assign rd  = if_instr[11:8];
	assign rs1 = (is_sw | is_imm8) ? if_instr[11:8] : if_instr[7:4];  // Store data / LxB
	assign rs2 = (is_sw | is_lw) ? if_instr[7:4] : if_instr[3:0];     // Address base
	assign regwrite = (is_rr | is_sll | is_lw | is_imm8) & (rd != '0);
	assign use1     = is_rr | is_sll | is_sw | is_imm8;
	assign use2     = is_rr | is_sw | is_lw;

	// Load in EX feeding a source used here
	assign load_use_stall = ex_load & ex_regwrite &
		((use1 & (ex_rd == rs1)) | (use2 & (ex_rd == rs2)));
	assign halt_seen = is_hlt | halt_q;

	always_comb begin
		rd1 = read_reg(rs1);
		rd2 = read_reg(rs2);
	end

	always_ff @(posedge clk) begin
		if (wb_regwrite) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// HLT has left decode; cleared if it turns out to be wrong-path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halt_q <= 1'b0;
		end else if (branch_taken) begin
			halt_q <= 1'b0;
		end else if (!stall && is_hlt) begin
			halt_q <= 1'b1;
		end
	end

	// ------------------------------
	// ID/EX register
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_instr <= INSTR_NOP;
			{ex_regwrite, ex_load, ex_store, ex_halt} <= '0;
		end else if (branch_taken || (!stall && (load_use_stall || halt_q))) begin
			ex_instr <= INSTR_NOP;  // Bubble
			{ex_regwrite, ex_load, ex_store, ex_halt} <= '0;
		end else if (!stall) begin
			ex_instr <= if_instr;
			{ex_regwrite, ex_load, ex_store, ex_halt} <= {regwrite, is_lw, is_sw, is_hlt};
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_pc  <= if_pc;
			ex_a   <= rd1;
			ex_b   <= rd2;
			ex_rs1 <= rs1;
			ex_rs2 <= rs2;
			ex_rd  <= rd;
		end else begin
			// Frozen; absorb writebacks so WB forwarding is not lost
			if (wb_regwrite && wb_rd == ex_rs1) begin
				ex_a <= wb_data;
			end
			if (wb_regwrite && wb_rd == ex_rs2) begin
				ex_b <= wb_data;
			end
		end
	end

	// Write enable for r0 is masked here and carried through EX and MEM
	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_regwrite |-> wb_rd != '0)
		else $error("writeback to r0");

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu16_pkg::*; (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           stall,
	input  wire word_t    ex_pc,
	input  wire word_t    ex_instr,
	input  wire word_t    ex_a,
	input  wire word_t    ex_b,
	input  wire reg_sel_t ex_rs1,
	input  wire reg_sel_t ex_rs2,
	input  wire reg_sel_t ex_rd,
	input  wire           ex_regwrite,
	input  wire           ex_load,
	input  wire           ex_store,
	input  wire           ex_halt,
	input  wire word_t    mem_fwd_data,   // Loaded word for a load
	input  wire word_t    wb_data,
	input  wire reg_sel_t wb_rd,
	input  wire           wb_regwrite,
	output logic          branch_taken,
	output word_t         branch_target,
	output word_t         mem_result,
	output word_t         mem_addr,
	output word_t         mem_wdata,
	output reg_sel_t      mem_rd,
	output logic          mem_regwrite,
	output logic          mem_load,
	output logic          mem_store,
	output logic          mem_halt
);

	opcode_t op;
	word_t   a, b, alu_y, addr, target;
	flags_t  flags, flags_y;
	logic    wr_flags, cond, take;

	// MEM holds the younger producer and wins
	function automatic word_t forward(input reg_sel_t sel, input word_t held);
		if (mem_regwrite && mem_rd == sel) begin
			return mem_fwd_data;
		end else if (wb_regwrite && wb_rd == sel) begin
			return wb_data;
		end
		return held;
	endfunction

	always_comb begin
		a = forward(ex_rs1, ex_a);
		b = forward(ex_rs2, ex_b);
	end

	// ------------------------------
	// ALU
	// ------------------------------
	assign op = ex_instr[15:12];

	always_comb begin
		case (op)
			OP_ADD:  alu_y = a + b;
			OP_SUB:  alu_y = a - b;
			OP_XOR:  alu_y = a ^ b;
			OP_SLL:  alu_y = a << ex_instr[3:0];
			OP_LHB:  alu_y = {ex_instr[7:0], a[7:0]};
			OP_LLB:  alu_y = {a[15:8], ex_instr[7:0]};
			default: alu_y = '0;
		endcase
	end

	assign wr_flags = op inside {OP_ADD, OP_SUB, OP_XOR};
	assign flags_y  = {alu_y == '0, alu_y[15]};  // {Z, N}
	assign addr     = b + {{11{ex_instr[3]}}, ex_instr[3:0], 1'b0};  // Base + offset*2

	// Branch condition against current flags
	always_comb begin
		case (ex_instr[11:9])
			CC_NE:   cond = !flags[FLAG_Z];
			CC_EQ:   cond = flags[FLAG_Z];
			CC_LT:   cond = flags[FLAG_N];
			CC_AL:   cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	assign take   = (op == OP_B) & cond;
	assign target = ex_pc + {{6{ex_instr[8]}}, ex_instr[8:0], 1'b0};  // ex_pc is PC + step

	// ------------------------------
	// Flags, branch and EX/MEM
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags        <= '0;
			branch_taken <= 1'b0;
			{mem_regwrite, mem_load, mem_store, mem_halt} <= '0;
		end else if (branch_taken) begin
			flags        <= '0;    // Flush clears flags
			branch_taken <= 1'b0;  // Instruction here is wrong-path
			{mem_regwrite, mem_load, mem_store, mem_halt} <= '0;
		end else if (!stall) begin
			if (wr_flags) begin
				flags <= flags_y;
			end
			branch_taken <= take;
			{mem_regwrite, mem_load, mem_store, mem_halt} <=
				{ex_regwrite, ex_load, ex_store, ex_halt};
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			branch_target <= target;
			mem_result    <= alu_y;
			mem_addr      <= addr;
			mem_wdata     <= a;  // SW data comes from the first read
			mem_rd        <= ex_rd;
		end
	end

	// A flush under a bus wait would drop the load or store in MEM
	a_flush_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |-> !stall)
		else $error("branch flush during a data bus wait");

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu16_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire word_t instr,           // Read combinationally at pc_out
	input  wire        stall,           // Data bus busy
	input  wire        load_use_stall,
	input  wire        halt_seen,
	input  wire        branch_taken,    // Registered, from execute
	input  wire word_t branch_target,
	output word_t      pc_out,
	output word_t      if_pc,           // PC + step of the decode instruction
	output word_t      if_instr
);

	word_t pc;
	word_t pc_plus;
	word_t pc_next;
	logic  hold;

	assign hold    = stall | load_use_stall | halt_seen;
	assign pc_plus = pc + PC_STEP;
	assign pc_next = branch_taken ? branch_target : pc_plus;
	assign pc_out  = pc;

	// ------------------------------
	// Program counter
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken || !hold) begin  // Redirect wins over hold
			pc <= pc_next;
		end
	end

	// IF/ID register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_instr <= INSTR_NOP;
		end else if (branch_taken) begin
			if_instr <= INSTR_NOP;  // Wrong-path fetch
		end else if (!hold) begin
			if_instr <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			if_pc <= pc_plus;
		end
	end

	// Branch targets from execute must keep instruction alignment
	a_pc_even: assert property (@(posedge clk) disable iff (!rst_n) !pc_out[0])
		else $error("pc_out is odd: %h", pc_out);

endmodule

`default_nettype wire

//--- design/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu16_pkg::*; (
	input  wire           clk,
	input  wire           rst_n,
	input  wire word_t    mem_result,
	input  wire word_t    mem_addr,
	input  wire word_t    mem_wdata,
	input  wire reg_sel_t mem_rd,
	input  wire           mem_regwrite,
	input  wire           mem_load,
	input  wire           mem_store,
	input  wire           mem_halt,
	input  wire word_t    dmem_rdata,
	input  wire           dmem_valid,
	output logic          mem_busy,      // Freezes every stage
	output word_t         mem_fwd_data,
	output logic          dmem_req,
	output logic          dmem_we,
	output word_t         dmem_addr,
	output word_t         dmem_wdata,
	output word_t         wb_data,
	output reg_sel_t      wb_rd,
	output logic          wb_regwrite,
	output logic          hlt
);

	mem_state_t state;
	logic       mem_op;

	assign mem_op = mem_load | mem_store;

	// Busy from arrival in MEM until the valid cycle
	assign mem_busy = (state == MEM_WAIT) ? !dmem_valid : mem_op;

	// EX/MEM is frozen while busy, so the bus fields hold by themselves
	assign dmem_req     = (state == MEM_WAIT);
	assign dmem_we      = mem_store;
	assign dmem_addr    = mem_addr;
	assign dmem_wdata   = mem_wdata;
	assign mem_fwd_data = mem_load ? dmem_rdata : mem_result;

	// ------------------------------
	// Data bus FSM
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= MEM_IDLE;
		end else begin
			case (state)
				MEM_IDLE: if (mem_op) state <= MEM_WAIT;
				MEM_WAIT: if (dmem_valid) state <= MEM_IDLE;  // Req drops next cycle
				default:  state <= MEM_IDLE;
			endcase
		end
	end

	// MEM/WB, bubble while waiting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_regwrite <= 1'b0;
			hlt         <= 1'b0;
		end else begin
			wb_regwrite <= mem_regwrite & !mem_busy;
			if (mem_halt) begin
				hlt <= 1'b1;  // Sticky until reset
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy) begin
			wb_data <= mem_fwd_data;  // Read data captured on valid
			wb_rd   <= mem_rd;
		end
	end

	// Relies on the pipeline freeze driven from mem_busy in every stage
	a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req && !dmem_valid |=> $stable(dmem_addr))
		else $error("dmem_addr changed during a request");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpu16_tb \
	-f cpu16.f -o cpu16_sim \
	&& ./obj_dir/cpu16_sim | tee /dev/stderr | grep -qx "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
